/* src/led_matrix_cfg.svh */
`ifndef LED_MATRIX_CFG_SVH
`define LED_MATRIX_CFG_SVH

// bus widths
`define LM_ADDR_W        16
`define LM_PIXEL_W       16
`define LM_REG_W         8

// panel geometry
`define LM_N_COLS        10
`define LM_N_ROWS        14
// two channels per row line
`define LM_N_CHANNELS    28
`define LM_ROW_BITS      32
`define LM_TIMER_W       8

// timing in clock cycles
`define LM_LINE_TIME     64
`define LM_LOAD_TIME     256
`define LM_SHIFT_PERIOD  16

// address map
`define LM_REG_BASE      16'h0040
`define LM_DEFAULT_FRAME 16'h1000

`endif

/* src/led_matrix_pkg.sv */
package led_matrix_pkg;

  // colour field being loaded
  typedef enum logic [1:0] {
    FIELD_BLUE,
    FIELD_GREEN,
    FIELD_RED
  } field_e;

  // scanner load sequence
  typedef enum logic [1:0] {
    LOAD_START,
    LOAD_WAIT_DATA,
    LOAD_STORE,
    LOAD_HOLD
  } load_state_e;

  // bit 0 is the latch phase, bits 2:1 the bank
  typedef enum logic [2:0] {
    BANK0       = 3'd0,
    BANK0_LATCH = 3'd1,
    BANK1       = 3'd2,
    BANK1_LATCH = 3'd3,
    BANK2       = 3'd4,
    BANK2_LATCH = 3'd5,
    BANK3       = 3'd6,
    BANK3_LATCH = 3'd7
  } latch_state_e;

  // register offsets inside the block
  typedef enum logic [3:0] {
    REG_CONTROL = 4'd0,
    REG_ADDR_L  = 4'd2,
    REG_ADDR_H  = 4'd3
  } reg_addr_e;

endpackage

/* src/matrix_regs.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module matrix_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reg_cyc_i,
  input  logic                  reg_we_i,
  input  logic [`LM_ADDR_W-1:0] reg_adr_i,
  input  logic [`LM_REG_W-1:0]  reg_dat_i,
  output logic [`LM_REG_W-1:0]  reg_dat_o,
  output logic                  reg_ack_o,
  output logic                  enable_o,
  output logic [`LM_ADDR_W-1:0] frame_base_o
);
  import led_matrix_pkg::*;

  localparam int AW = `LM_ADDR_W;
  localparam int DW = `LM_REG_W;
  localparam logic [AW-1:0] BLOCK_BASE = `LM_REG_BASE;

  logic       hit;
  logic [3:0] offset;
  logic       valid;

  // block decode ignores the low nibble
  assign hit    = reg_cyc_i && (reg_adr_i[AW-1:4] == BLOCK_BASE[AW-1:4]);
  assign offset = reg_adr_i[3:0];

  // read mux and valid offset check
  always_comb begin
    valid     = 1'b0;
    reg_dat_o = '0;
    if (hit) begin
      case (offset)
        REG_CONTROL: begin
          valid     = 1'b1;
          reg_dat_o = DW'(enable_o);
        end
        REG_ADDR_L: begin
          valid     = 1'b1;
          reg_dat_o = frame_base_o[DW-1:0];
        end
        REG_ADDR_H: begin
          valid     = 1'b1;
          reg_dat_o = DW'(frame_base_o[AW-1:DW]);
        end
        default: begin
          valid     = 1'b0;
          reg_dat_o = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= valid;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      enable_o     <= 1'b1;
      frame_base_o <= `LM_DEFAULT_FRAME;
    end else if (valid && reg_we_i) begin
      case (offset)
        REG_CONTROL: enable_o <= reg_dat_i[0];
        REG_ADDR_L:  frame_base_o[DW-1:0] <= reg_dat_i;
        REG_ADDR_H:  frame_base_o[AW-1:DW] <= reg_dat_i[AW-DW-1:0];
        default:     enable_o <= enable_o;
      endcase
    end
  end

endmodule

/* src/frame_reader.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module frame_reader (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_req_i,
  input  logic [`LM_ADDR_W-1:0]  fetch_addr_i,
  output logic                   fetch_ack_o,
  output logic [`LM_PIXEL_W-1:0] fetch_data_o,
  output logic                   frame_cyc_o,
  output logic                   frame_stb_o,
  output logic [`LM_ADDR_W-1:0]  frame_adr_o,
  input  logic [`LM_PIXEL_W-1:0] frame_dat_i,
  input  logic                   frame_ack_i
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_BUS,
    RD_DONE
  } rd_state_e;

  rd_state_e state;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: if (fetch_req_i) state <= RD_BUS;
        RD_BUS:  if (frame_ack_i) state <= RD_DONE;
        // hold ack until the scanner drops its request
        RD_DONE: if (!fetch_req_i) state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RD_IDLE && fetch_req_i) begin
      frame_adr_o <= fetch_addr_i;
    end
    if (state == RD_BUS && frame_ack_i) begin
      fetch_data_o <= frame_dat_i;
    end
  end

  // single beat read with cyc and stb moving together
  assign frame_cyc_o = (state == RD_BUS);
  assign frame_stb_o = (state == RD_BUS);
  assign fetch_ack_o = (state == RD_DONE);

endmodule

/* src/pixel_scanner.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module pixel_scanner (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`LM_ADDR_W-1:0]             frame_base_i,
  output logic                              fetch_req_o,
  output logic [`LM_ADDR_W-1:0]             fetch_addr_o,
  input  logic                              fetch_ack_i,
  input  logic [`LM_PIXEL_W-1:0]            fetch_data_i,
  output logic [`LM_PIXEL_W-1:0]            pixel_o,
  output led_matrix_pkg::field_e            field_o,
  output logic                              timer_wr_o,
  output logic [$clog2(`LM_N_CHANNELS)-1:0] timer_idx_o,
  output logic                              line_start_o,
  output logic                              loading_o,
  output logic                              col_first_o,
  output logic                              frame_complete_o
);
  import led_matrix_pkg::*;

  localparam int AW         = `LM_ADDR_W;
  localparam int IDX_W      = $clog2(`LM_N_CHANNELS);
  localparam int COL_W      = $clog2(`LM_N_COLS);
  localparam int LINE_W     = $clog2(`LM_LINE_TIME + 1);
  localparam int LOAD_W     = $clog2(`LM_LOAD_TIME + 1);
  localparam int ROW_STRIDE = 32;

  logic [LINE_W-1:0] line_timer;
  logic [LOAD_W-1:0] load_timer;
  load_state_e       load_state;
  logic [IDX_W-1:0]  pixel_idx;
  logic [COL_W-1:0]  col;
  logic [AW-1:0]     frame_base_q;
  logic [AW-1:0]     x_pos;
  logic [AW-1:0]     y_pos;
  logic [AW-1:0]     word_off;

  // ========================================
  // pixel addressing
  // ========================================

  // each column spans two frame pixels per row line pair
  assign x_pos = (AW'(col) << 1) | AW'(pixel_idx[0]);
  assign y_pos = AW'(pixel_idx[IDX_W-1:1]);
  // neighbouring pixels swap on odd rows
  assign word_off = y_pos * AW'(ROW_STRIDE) + {x_pos[AW-1:1], x_pos[0] ^ y_pos[0]};
  // byte address, two bytes per pixel
  assign fetch_addr_o = frame_base_q + (word_off << 1);

  assign loading_o   = (line_timer == '0);
  assign col_first_o = (col == '0) && (field_o == FIELD_BLUE);

  // ========================================
  // line and load sequencing
  // ========================================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line_timer       <= LINE_W'(`LM_LINE_TIME);
      load_timer       <= LOAD_W'(`LM_LOAD_TIME);
      load_state       <= LOAD_START;
      pixel_idx        <= '0;
      col              <= '0;
      field_o          <= FIELD_BLUE;
      frame_base_q     <= `LM_DEFAULT_FRAME;
      fetch_req_o      <= 1'b0;
      timer_wr_o       <= 1'b0;
      line_start_o     <= 1'b0;
      frame_complete_o <= 1'b0;
    end else begin
      timer_wr_o   <= 1'b0;
      line_start_o <= 1'b0;
      if (line_timer != '0) begin
        line_timer <= line_timer - 1'b1;
        load_timer <= LOAD_W'(`LM_LOAD_TIME);
      end else begin
        if (load_timer != '0) begin
          load_timer <= load_timer - 1'b1;
        end
        case (load_state)
          LOAD_START: begin
            // previous handshake must be fully closed
            if (!fetch_ack_i) begin
              fetch_req_o      <= 1'b1;
              frame_complete_o <= 1'b0;
              load_state       <= LOAD_WAIT_DATA;
            end
          end
          LOAD_WAIT_DATA: begin
            if (fetch_ack_i) begin
              fetch_req_o <= 1'b0;
              load_state  <= LOAD_STORE;
            end
          end
          LOAD_STORE: begin
            // lut value is ready on the following cycle
            timer_wr_o <= 1'b1;
            if (pixel_idx == IDX_W'(`LM_N_CHANNELS - 1)) begin
              pixel_idx  <= '0;
              load_state <= LOAD_HOLD;
              case (field_o)
                FIELD_BLUE:  field_o <= FIELD_GREEN;
                FIELD_GREEN: field_o <= FIELD_RED;
                default:     field_o <= FIELD_BLUE;
              endcase
            end else begin
              pixel_idx  <= pixel_idx + 1'b1;
              load_state <= LOAD_START;
            end
          end
          LOAD_HOLD: begin
            if (load_timer == '0) begin
              line_timer   <= LINE_W'(`LM_LINE_TIME);
              line_start_o <= 1'b1;
              load_state   <= LOAD_START;
              // field already wrapped to blue after red
              if (field_o == FIELD_BLUE) begin
                if (col == COL_W'(`LM_N_COLS - 1)) begin
                  col              <= '0;
                  frame_base_q     <= frame_base_i;
                  frame_complete_o <= 1'b1;
                end else begin
                  col <= col + 1'b1;
                end
              end
            end
          end
          default: load_state <= LOAD_START;
        endcase
      end
    end
  end

  // fetched pixel and write index
  always_ff @(posedge clk) begin
    if (load_state == LOAD_WAIT_DATA && fetch_ack_i) begin
      pixel_o <= fetch_data_i;
    end
    if (load_state == LOAD_STORE) begin
      timer_idx_o <= pixel_idx;
    end
  end

endmodule

/* src/field_lut.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module field_lut (
  input  logic                   clk,
  input  logic [`LM_PIXEL_W-1:0] pixel_i,
  input  led_matrix_pkg::field_e field_i,
  output logic [`LM_TIMER_W-1:0] value_o
);
  import led_matrix_pkg::*;

  localparam int TW    = `LM_TIMER_W;
  localparam int LUT_N = 64;

  logic [5:0]    component;
  logic [TW-1:0] lut [LUT_N];

  // 565 split with the 5 bit fields padded to 6
  always_comb begin
    case (field_i)
      FIELD_RED:   component = {pixel_i[15:11], 1'b0};
      FIELD_GREEN: component = pixel_i[10:5];
      FIELD_BLUE:  component = {pixel_i[4:0], 1'b0};
      default:     component = '0;
    endcase
  end

  // on-time scaled to the line length
  for (genvar i = 0; i < LUT_N; i++) begin : g_lut
    assign lut[i] = TW'(i * `LM_LINE_TIME / LUT_N);
  end

  always_ff @(posedge clk) begin
    value_o <= lut[component];
  end

endmodule

/* src/row_pwm.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module row_pwm (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              timer_wr_i,
  input  logic [$clog2(`LM_N_CHANNELS)-1:0] timer_idx_i,
  input  logic [`LM_TIMER_W-1:0]            timer_value_i,
  input  logic                              line_start_i,
  input  logic                              enable_i,
  output logic [`LM_ROW_BITS-1:0]           row_state_o
);

  localparam int NCH = `LM_N_CHANNELS;
  localparam int TW  = `LM_TIMER_W;

  logic [TW-1:0]  loaded [NCH];
  logic [TW-1:0]  active [NCH];
  logic [NCH-1:0] lit;

  // next line values are filled during the load window
  always_ff @(posedge clk) begin
    if (timer_wr_i) begin
      loaded[timer_idx_i] <= timer_value_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < NCH; k++) begin
        active[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NCH; k++) begin
        if (line_start_i) begin
          active[k] <= loaded[k];
        end else if (active[k] != '0) begin
          active[k] <= active[k] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NCH; k++) begin
      lit[k] = (active[k] != '0);
    end
  end

  // spare top bits stay dark
  assign row_state_o = enable_i ? {{(`LM_ROW_BITS - NCH){1'b0}}, lit} : '0;

endmodule

/* src/row_latch_seq.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module row_latch_seq (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`LM_ROW_BITS-1:0] row_state_i,
  output logic [7:0]              row_data_o,
  output logic [3:0]              latch_row_bank_o
);
  import led_matrix_pkg::*;

  localparam int BW = 8;

  latch_state_e state;
  logic [1:0]   bank;
  logic [1:0]   next_bank;

  assign bank      = state[2:1];
  assign next_bank = bank + 2'd1;

  // strobe on the second cycle of each bank
  assign latch_row_bank_o = state[0] ? (4'b0001 << bank) : 4'b0000;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= BANK0;
      row_data_o <= '0;
    end else begin
      state <= latch_state_e'(state + 3'd1);
      // byte for the next bank is held over both of its cycles
      if (state[0]) begin
        row_data_o <= row_state_i[next_bank * BW +: BW];
      end
    end
  end

endmodule

/* src/col_shift_ctrl.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module col_shift_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic loading_i,
  output logic col_advance_o,
  output logic col_rclk_o
);

  localparam int PERIOD = `LM_SHIFT_PERIOD;
  localparam int HALF   = PERIOD / 2;
  localparam int CNT_W  = $clog2(PERIOD + 1);

  logic             loading_q;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      loading_q <= 1'b0;
      count     <= '0;
    end else begin
      loading_q <= loading_i;
      // restart on each new load window
      if (loading_i && !loading_q) begin
        count <= CNT_W'(PERIOD);
      end else if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  // rclk in the upper half, advance in the lower
  assign col_rclk_o    = (count > CNT_W'(HALF));
  assign col_advance_o = (count != '0) && (count <= CNT_W'(HALF));

endmodule

/* src/led_matrix_top.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module led_matrix_top (
  input  logic                     clk,
  input  logic                     rst,
  // register slave
  input  logic                     reg_cyc_i,
  input  logic                     reg_we_i,
  input  logic [`LM_ADDR_W-1:0]    reg_adr_i,
  input  logic [`LM_REG_W-1:0]     reg_dat_i,
  output logic [`LM_REG_W-1:0]     reg_dat_o,
  output logic                     reg_ack_o,
  // frame memory master
  output logic                     frame_cyc_o,
  output logic                     frame_stb_o,
  output logic [`LM_ADDR_W-1:0]    frame_adr_o,
  input  logic [`LM_PIXEL_W-1:0]   frame_dat_i,
  input  logic                     frame_ack_i,
  // panel drive
  output logic [7:0]               row_data_o,
  output logic [3:0]               latch_row_bank_o,
  output logic                     col_first_o,
  output logic                     col_advance_o,
  output logic                     col_rclk_o,
  output logic                     frame_complete_o
);
  import led_matrix_pkg::*;

  localparam int IDX_W = $clog2(`LM_N_CHANNELS);

  logic                     enable;
  logic [`LM_ADDR_W-1:0]    frame_base;
  logic                     fetch_req;
  logic                     fetch_ack;
  logic [`LM_ADDR_W-1:0]    fetch_addr;
  logic [`LM_PIXEL_W-1:0]   fetch_data;
  logic [`LM_PIXEL_W-1:0]   pixel;
  field_e                   field;
  logic [`LM_TIMER_W-1:0]   timer_value;
  logic                     timer_wr;
  logic [IDX_W-1:0]         timer_idx;
  logic                     line_start;
  logic                     loading;
  logic [`LM_ROW_BITS-1:0]  row_state;

  matrix_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .reg_cyc_i    (reg_cyc_i),
    .reg_we_i     (reg_we_i),
    .reg_adr_i    (reg_adr_i),
    .reg_dat_i    (reg_dat_i),
    .reg_dat_o    (reg_dat_o),
    .reg_ack_o    (reg_ack_o),
    .enable_o     (enable),
    .frame_base_o (frame_base)
  );

  frame_reader u_reader (
    .clk          (clk),
    .rst          (rst),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .fetch_ack_o  (fetch_ack),
    .fetch_data_o (fetch_data),
    .frame_cyc_o  (frame_cyc_o),
    .frame_stb_o  (frame_stb_o),
    .frame_adr_o  (frame_adr_o),
    .frame_dat_i  (frame_dat_i),
    .frame_ack_i  (frame_ack_i)
  );

  pixel_scanner u_scanner (
    .clk              (clk),
    .rst              (rst),
    .frame_base_i     (frame_base),
    .fetch_req_o      (fetch_req),
    .fetch_addr_o     (fetch_addr),
    .fetch_ack_i      (fetch_ack),
    .fetch_data_i     (fetch_data),
    .pixel_o          (pixel),
    .field_o          (field),
    .timer_wr_o       (timer_wr),
    .timer_idx_o      (timer_idx),
    .line_start_o     (line_start),
    .loading_o        (loading),
    .col_first_o      (col_first_o),
    .frame_complete_o (frame_complete_o)
  );

  field_lut u_lut (
    .clk     (clk),
    .pixel_i (pixel),
    .field_i (field),
    .value_o (timer_value)
  );

  row_pwm u_pwm (
    .clk           (clk),
    .rst           (rst),
    .timer_wr_i    (timer_wr),
    .timer_idx_i   (timer_idx),
    .timer_value_i (timer_value),
    .line_start_i  (line_start),
    .enable_i      (enable),
    .row_state_o   (row_state)
  );

  row_latch_seq u_latch (
    .clk              (clk),
    .rst              (rst),
    .row_state_i      (row_state),
    .row_data_o       (row_data_o),
    .latch_row_bank_o (latch_row_bank_o)
  );

  col_shift_ctrl u_shift (
    .clk           (clk),
    .rst           (rst),
    .loading_i     (loading),
    .col_advance_o (col_advance_o),
    .col_rclk_o    (col_rclk_o)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

/* tb/led_matrix_tb.sv */
`timescale 1ns/1ps
`include "led_matrix_cfg.svh"

module led_matrix_tb;
  import led_matrix_pkg::*;

  localparam int PERIOD_NS   = 40;
  localparam int NCH         = `LM_N_CHANNELS;
  localparam int LINE        = `LM_LINE_TIME;
  localparam int SLOT_MAX    = `LM_LINE_TIME + `LM_LOAD_TIME + 1 + 64;
  localparam int WATCHDOG_NS = 3 * 30 * SLOT_MAX * PERIOD_NS + 20000;
  localparam int RUN_SLOTS   = 62;
  localparam logic [15:0] REG_BLOCK = `LM_REG_BASE;

  logic clk, rst;
  logic reg_cyc_i, reg_we_i, reg_ack_o, frame_cyc_o, frame_stb_o, frame_ack_i;
  logic [15:0] reg_adr_i, frame_adr_o, frame_dat_i;
  logic [7:0] reg_dat_i, reg_dat_o, row_data_o;
  logic [3:0] latch_row_bank_o;
  logic col_first_o, col_advance_o, col_rclk_o, frame_complete_o;
  logic access_valid;

  int errs [5];
  bit checks_on, pwm_armed, pwm_on, mem_busy, rng_seeded;
  int idx, fld, col, ofs, mem_wait;
  int pix [NCH];
  int val_next [NCH];
  int val_cur [NCH];
  logic [15:0] exp_base, written_base;
  int slot_count, first_count, fc_rises, shift_phase;
  logic rclk_prev, adv_prev, fc_prev;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(4)) u_clk (.clk_o(clk), .rst_o(rst));

  led_matrix_top DUT (
    .clk(clk), .rst(rst),
    .reg_cyc_i(reg_cyc_i), .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i),
    .reg_dat_i(reg_dat_i), .reg_dat_o(reg_dat_o), .reg_ack_o(reg_ack_o),
    .frame_cyc_o(frame_cyc_o), .frame_stb_o(frame_stb_o), .frame_adr_o(frame_adr_o),
    .frame_dat_i(frame_dat_i), .frame_ack_i(frame_ack_i),
    .row_data_o(row_data_o), .latch_row_bank_o(latch_row_bank_o),
    .col_first_o(col_first_o), .col_advance_o(col_advance_o), .col_rclk_o(col_rclk_o),
    .frame_complete_o(frame_complete_o)
  );

  task automatic report_error(input int test_id, input string msg);
    $display("** Error: %0t ns: %s", $time, msg);
    errs[test_id]++;
  endtask

  function automatic logic [3:0] rotate_bank(input logic [3:0] b);
    return {b[2:0], b[3]};
  endfunction

  // 565 component scaled to the line length
  function automatic int table_value(input int pixel, input int field);
    int c;
    case (field)
      0: c = (pixel & 31) * 2;
      1: c = (pixel >> 5) & 63;
      default: c = ((pixel >> 11) & 31) * 2;
    endcase
    return c * LINE / 64;
  endfunction

  function automatic logic [15:0] pixel_address(input logic [15:0] base, input int column,
                                                input int index);
    int x, y, off;
    x = column * 2 + index % 2;
    y = index / 2;
    off = y * 32 + (x / 2) * 2 + ((x ^ y) & 1);
    return base + 16'(2 * off);
  endfunction

  // ========================================
  // concurrent checks
  // ========================================

  assign access_valid = reg_cyc_i && (reg_adr_i[15:4] == REG_BLOCK[15:4]) &&
                        (reg_adr_i[3:0] == REG_CONTROL || reg_adr_i[3:0] == REG_ADDR_L ||
                         reg_adr_i[3:0] == REG_ADDR_H);

  a_reg_ack: assert property (@(posedge clk) disable iff (!checks_on)
    reg_ack_o == $past(access_valid))
    else report_error(0, "reg_ack_o does not follow a valid access by one cycle");
  a_frame_strobe: assert property (@(posedge clk) disable iff (!checks_on)
    frame_cyc_o == frame_stb_o)
    else report_error(1, "frame_cyc_o and frame_stb_o do not move together");
  a_bank_onehot: assert property (@(posedge clk) disable iff (!checks_on)
    $onehot0(latch_row_bank_o))
    else report_error(2, "latch_row_bank_o is not zero or one-hot");
  a_bank_alternate: assert property (@(posedge clk) disable iff (!checks_on)
    (latch_row_bank_o != 4'b0) != ($past(latch_row_bank_o) != 4'b0))
    else report_error(2, "latch pulse is not on every other cycle");
  a_bank_order: assert property (@(posedge clk) disable iff (!checks_on)
    (latch_row_bank_o == 4'b0) || ($past(latch_row_bank_o, 2) == 4'b0) ||
    (latch_row_bank_o == rotate_bank($past(latch_row_bank_o, 2))))
    else report_error(2, "banks do not cycle 0 to 3");
  a_bank_stable: assert property (@(posedge clk) disable iff (!checks_on)
    (latch_row_bank_o == 4'b0) || (row_data_o == $past(row_data_o)))
    else report_error(2, "row_data_o changed between the two cycles of a bank");
  a_spare_bits: assert property (@(posedge clk) disable iff (!checks_on)
    (latch_row_bank_o != 4'b1000) || (row_data_o[7:4] == 4'b0))
    else report_error(3, "row bits 28 to 31 are not zero");
  a_col_exclusive: assert property (@(posedge clk) disable iff (!checks_on)
    !(col_rclk_o && col_advance_o))
    else report_error(4, "col_rclk_o and col_advance_o high together");

  // ========================================
  // frame memory model and monitors
  // ========================================

  always @(negedge clk) begin : frame_model
    logic [31:0] prod;
    int b;
    int exp_bit;
    if (!rng_seeded) begin
      void'($urandom(31946));
      rng_seeded = 1'b1;
    end
    if (frame_ack_i) begin
      // transfer completed on the last rising edge
      assert (!frame_cyc_o && !frame_stb_o)
        else report_error(1, "cyc or stb still high the cycle after ack");
      pix[idx] = int'(frame_dat_i);
      frame_ack_i = 1'b0;
      mem_busy = 1'b0;
      idx++;
      if (idx == NCH) begin
        for (int k = 0; k < NCH; k++) val_next[k] = table_value(pix[k], fld);
        idx = 0;
        fld = (fld + 1) % 3;
        if (fld == 0) col = (col + 1) % `LM_N_COLS;
      end
    end else if (frame_cyc_o && frame_stb_o) begin
      if (!mem_busy) begin
        assert (frame_adr_o == pixel_address(exp_base, col, idx))
          else report_error(1, $sformatf("fetch address %h, expected %h", frame_adr_o,
                                         pixel_address(exp_base, col, idx)));
        mem_busy = 1'b1;
        mem_wait = $urandom_range(4, 1);
      end
      mem_wait--;
      if (mem_wait == 0) begin
        prod = 32'(frame_adr_o) * 32'h0421;
        frame_dat_i = prod[15:0];
        frame_ack_i = 1'b1;
      end
    end else if (mem_busy) begin
      report_error(1, "frame cycle dropped before the memory acked");
      mem_busy = 1'b0;
    end

    // new base shows up only at frame end
    if (frame_complete_o && !fc_prev) begin
      fc_rises++;
      exp_base = written_base;
    end

    // offset counted from the line start
    // row data lags row state by two cycles
    if (DUT.u_scanner.line_start_o) begin
      ofs = -1;
      val_cur = val_next;
      pwm_armed = 1'b1;
    end else begin
      ofs++;
    end
    if (pwm_armed && pwm_on && latch_row_bank_o != 4'b0 && ofs >= 2 && ofs - 2 < LINE) begin
      b = 0;
      for (int j = 0; j < 4; j++) if (latch_row_bank_o[j]) b = j;
      for (int i = 0; i < 8; i++) begin
        if (b * 8 + i < NCH) begin
          exp_bit = (ofs - 2 < val_cur[b * 8 + i]) ? 1 : 0;
          assert (int'(row_data_o[i]) == exp_bit)
            else report_error(3, $sformatf("channel %0d at offset %0d is %0d, expected %0d",
                                           b * 8 + i, ofs - 2, row_data_o[i], exp_bit));
        end
      end
    end

    // one rclk then one advance per slot
    if (col_rclk_o && !rclk_prev) begin
      assert (shift_phase == 0) else report_error(4, "second rclk pulse before advance");
      shift_phase = 1;
      if (slot_count > 0 && slot_count % 30 == 0) begin
        assert (first_count == 1 && fc_rises == 1)
          else report_error(4, $sformatf("30 slots had %0d col_first and %0d frame ends",
                                         first_count, fc_rises));
        first_count = 0;
        fc_rises = 0;
      end
      if (col_first_o) first_count++;
      slot_count++;
    end
    if (col_advance_o && !adv_prev) begin
      assert (shift_phase == 1) else report_error(4, "advance pulse without rclk before it");
      shift_phase = 0;
    end
    rclk_prev = col_rclk_o;
    adv_prev = col_advance_o;
    fc_prev = frame_complete_o;
  end

  // ========================================
  // stimulus
  // ========================================

  task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat, output logic acked);
    reg_cyc_i = 1'b1;
    reg_we_i = we;
    reg_adr_i = adr;
    reg_dat_i = wdat;
    @(negedge clk);
    rdat = reg_dat_o;
    acked = reg_ack_o;
    reg_cyc_i = 1'b0;
    reg_we_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic check_reg(input logic [15:0] adr, input logic [7:0] exp_dat,
                           input logic exp_ack);
    logic [7:0] rdat;
    logic acked;
    bus_cycle(1'b0, adr, 8'h00, rdat, acked);
    assert (rdat == exp_dat && acked == exp_ack)
      else report_error(0, $sformatf("read %h gave %h ack %0d, expected %h ack %0d",
                                     adr, rdat, acked, exp_dat, exp_ack));
  endtask

  task automatic write_reg(input logic [15:0] adr, input logic [7:0] wdat,
                           input logic exp_ack);
    logic [7:0] rdat;
    logic acked;
    bus_cycle(1'b1, adr, wdat, rdat, acked);
    assert (acked == exp_ack)
      else report_error(0, $sformatf("write %h ack %0d, expected %0d", adr, acked, exp_ack));
  endtask

  task automatic test_registers;
    // enable resets to 1, so clear it once before setting it again
    write_reg(REG_BLOCK | 16'(REG_CONTROL), 8'h00, 1'b1);
    check_reg(REG_BLOCK | 16'(REG_CONTROL), 8'h00, 1'b1);
    write_reg(REG_BLOCK | 16'(REG_CONTROL), 8'h01, 1'b1);
    write_reg(REG_BLOCK | 16'(REG_ADDR_L), 8'h40, 1'b1);
    write_reg(REG_BLOCK | 16'(REG_ADDR_H), 8'h20, 1'b1);
    written_base = 16'h2040;
    check_reg(REG_BLOCK | 16'(REG_CONTROL), 8'h01, 1'b1);
    check_reg(REG_BLOCK | 16'(REG_ADDR_L), 8'h40, 1'b1);
    check_reg(REG_BLOCK | 16'(REG_ADDR_H), 8'h20, 1'b1);
    // unused offset and outside the block
    check_reg(REG_BLOCK | 16'h0001, 8'h00, 1'b0);
    write_reg(16'h0050 | 16'(REG_ADDR_H), 8'hff, 1'b0);
    check_reg(16'h0050 | 16'(REG_ADDR_H), 8'h00, 1'b0);
    check_reg(REG_BLOCK | 16'(REG_ADDR_H), 8'h20, 1'b1);
  endtask

  task automatic test_enable_off;
    pwm_on = 1'b0;
    write_reg(REG_BLOCK | 16'(REG_CONTROL), 8'h00, 1'b1);
    // watch a whole display line where channels would be lit
    while (!DUT.u_scanner.line_start_o) @(negedge clk);
    repeat (LINE) begin
      @(negedge clk);
      assert (row_data_o == 8'h00) else report_error(3, "row bits lit while disabled");
    end
  endtask

  task automatic report_test(input int test_id, input string name);
    $display("test %0d %s: %s, %0d errors", test_id + 1, name,
             (errs[test_id] == 0) ? "passed" : "failed", errs[test_id]);
  endtask

  initial begin : main
    int total;
    int failed;
    reg_cyc_i = 1'b0;
    reg_we_i = 1'b0;
    reg_adr_i = 16'h0000;
    reg_dat_i = 8'h00;
    frame_ack_i = 1'b0;
    frame_dat_i = 16'h0000;
    checks_on = 1'b0;
    pwm_armed = 1'b0;
    pwm_on = 1'b1;
    exp_base = `LM_DEFAULT_FRAME;
    written_base = `LM_DEFAULT_FRAME;
    for (int t = 0; t < 5; t++) errs[t] = 0;
    @(negedge clk);
    while (rst) @(negedge clk);
    repeat (2) @(negedge clk);
    checks_on = 1'b1;
    test_registers();
    report_test(0, "register access");
    wait (slot_count >= RUN_SLOTS);
    @(negedge clk);
    report_test(1, "frame fetch");
    report_test(2, "bank multiplexing");
    test_enable_off();
    report_test(3, "pwm on-time");
    report_test(4, "column control");
    total = 0;
    failed = 0;
    for (int t = 0; t < 5; t++) begin
      total += errs[t];
      if (errs[t] != 0) failed++;
    end
    $display("tests run 5, failed %0d, errors %0d", failed, total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

/* led_matrix.f */
+incdir+src
src/led_matrix_pkg.sv
src/matrix_regs.sv
src/frame_reader.sv
src/pixel_scanner.sv
src/field_lut.sv
src/row_pwm.sv
src/row_latch_seq.sv
src/col_shift_ctrl.sv
src/led_matrix_top.sv
tb/tb_clock_gen.sv
tb/led_matrix_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f led_matrix.f \
  --top-module led_matrix_tb -o led_matrix_sim
./obj_dir/led_matrix_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
